/* register_table.f */
+incdir+rtl
rtl/spu_pkg.sv
rtl/register_storage.sv
rtl/operand_bypass.sv
rtl/operand_stage.sv
rtl/register_table.sv
test/register_table_properties.sv
test/register_table_tb.sv

/* rtl/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import spu_pkg::*; (
	input	reg_addr_t	read_addr,		// Source register of this port
	input	quad_t		raw_data,		// Value from the array

	input	logic		write_even,
	input	logic		write_odd,
	input	reg_addr_t	rt_addr_even,
	input	reg_addr_t	rt_addr_odd,
	input	quad_t		rt_even,
	input	quad_t		rt_odd,

	output	quad_t		operand			// Newest value of read_addr
);

	logic	hit_even;						// Even writeback targets this port
	logic	hit_odd;						// Odd writeback targets this port

	assign hit_even = write_even && (read_addr == rt_addr_even);
	assign hit_odd  = write_odd  && (read_addr == rt_addr_odd);

	// Same priority as the array, so the forwarded value is exactly
	// what the register will hold once the edge has passed
	always_comb begin
		if (hit_odd) begin
			operand = rt_odd;
		end else if (hit_even) begin
			operand = rt_even;
		end else begin
			operand = raw_data;				// No write in flight
		end
	end

endmodule

/* rtl/operand_stage.sv */
`timescale 1ns/1ps

`include "spu_params.svh"

module operand_stage import spu_pkg::*; (
	input	logic		clk,
	input	logic		reset,

	input	logic		issue_even,		// Even instruction enters this cycle
	input	logic		issue_odd,		// Odd instruction enters this cycle

	input	quad_t		operand_in [`SPU_READ_PORTS],	// Forwarded operands

	// Even pipe operands
	output	quad_t		ra_even,
	output	quad_t		rb_even,
	output	quad_t		rc_even,

	// Odd pipe operands
	output	quad_t		ra_odd,
	output	quad_t		rb_odd,
	output	quad_t		rt_st_odd,		// Store data

	output	logic		operands_valid_even,
	output	logic		operands_valid_odd
);

	// Positions in operand_in, same order as the read ports
	localparam int IDX_RC_EVEN	= 0;
	localparam int IDX_RA_EVEN	= 1;
	localparam int IDX_RB_EVEN	= 2;
	localparam int IDX_RT_ODD	= 3;
	localparam int IDX_RA_ODD	= 4;
	localparam int IDX_RB_ODD	= 5;

	// Even group, loads only on its own issue strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			ra_even <= '0;
			rb_even <= '0;
			rc_even <= '0;
		end else if (issue_even) begin
			ra_even <= operand_in[IDX_RA_EVEN];
			rb_even <= operand_in[IDX_RB_EVEN];
			rc_even <= operand_in[IDX_RC_EVEN];
		end
	end

	// Odd group, independent of the even side
	always_ff @(posedge clk) begin
		if (reset) begin
			ra_odd    <= '0;
			rb_odd    <= '0;
			rt_st_odd <= '0;
		end else if (issue_odd) begin
			ra_odd    <= operand_in[IDX_RA_ODD];
			rb_odd    <= operand_in[IDX_RB_ODD];
			rt_st_odd <= operand_in[IDX_RT_ODD];
		end
	end

	// One-cycle pulse, marks the cycle the operands are fresh
	always_ff @(posedge clk) begin
		if (reset) begin
			operands_valid_even <= 1'b0;
			operands_valid_odd  <= 1'b0;
		end else begin
			operands_valid_even <= issue_even;
			operands_valid_odd  <= issue_odd;
		end
	end

endmodule

/* rtl/register_storage.sv */
`timescale 1ns/1ps

`include "spu_params.svh"

module register_storage import spu_pkg::*; (
	input	logic		clk,
	input	logic		reset,

	// Writeback from the even pipe
	input	logic		write_even,
	input	reg_addr_t	rt_addr_even,
	input	quad_t		rt_even,

	// Writeback from the odd pipe
	input	logic		write_odd,
	input	reg_addr_t	rt_addr_odd,
	input	quad_t		rt_odd,

	// Raw read ports, no forwarding here
	input	reg_addr_t	read_addr [`SPU_READ_PORTS],
	output	quad_t		read_data [`SPU_READ_PORTS]
);

	quad_t	regs [`SPU_NUM_REGS];			// The register file itself

	// Two writes per edge. The odd assignment comes last, so on an
	// address collision its nonblocking update is the one that lands.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `SPU_NUM_REGS; i++) begin
				regs[i] <= '0;				// Whole file cleared
			end
		end else begin
			if (write_even) begin
				regs[rt_addr_even] <= rt_even;
			end
			if (write_odd) begin
				regs[rt_addr_odd] <= rt_odd;	// Odd wins a collision
			end
		end
	end

	// Six independent combinational reads of committed state
	always_comb begin
		for (int p = 0; p < `SPU_READ_PORTS; p++) begin
			read_data[p] = regs[read_addr[p]];
		end
	end

endmodule

/* rtl/register_table.sv */
`timescale 1ns/1ps

`include "spu_params.svh"

module register_table import spu_pkg::*; (
	input	logic		clk,
	input	logic		reset,

	// Instructions from the two issue slots
	input	instr_t		instr_even,
	input	instr_t		instr_odd,
	input	logic		issue_even,
	input	logic		issue_odd,

	// Writeback, one port per pipe
	input	logic		write_even,
	input	reg_addr_t	rt_addr_even,
	input	quad_t		rt_even,
	input	logic		write_odd,
	input	reg_addr_t	rt_addr_odd,
	input	quad_t		rt_odd,

	// Registered operands
	output	quad_t		ra_even,
	output	quad_t		rb_even,
	output	quad_t		rc_even,
	output	quad_t		ra_odd,
	output	quad_t		rb_odd,
	output	quad_t		rt_st_odd,

	output	logic		operands_valid_even,
	output	logic		operands_valid_odd
);

	reg_addr_t	read_addr [`SPU_READ_PORTS];		// Sliced source fields
	quad_t		raw_data  [`SPU_READ_PORTS];		// Straight from the array
	quad_t		fwd_data  [`SPU_READ_PORTS];		// After same-cycle forwarding

	// Fields are read regardless of format, unused ones are harmless
	assign read_addr[0] = instr_even[`SPU_FIELD_RC_LO:`SPU_FIELD_RC_HI];
	assign read_addr[1] = instr_even[`SPU_FIELD_RA_LO:`SPU_FIELD_RA_HI];
	assign read_addr[2] = instr_even[`SPU_FIELD_RB_LO:`SPU_FIELD_RB_HI];
	// Odd store data shares the rc position
	assign read_addr[3] = instr_odd[`SPU_FIELD_RC_LO:`SPU_FIELD_RC_HI];
	assign read_addr[4] = instr_odd[`SPU_FIELD_RA_LO:`SPU_FIELD_RA_HI];
	assign read_addr[5] = instr_odd[`SPU_FIELD_RB_LO:`SPU_FIELD_RB_HI];

	register_storage storage0 (
		.clk			(clk),
		.reset			(reset),
		.write_even		(write_even),
		.rt_addr_even	(rt_addr_even),
		.rt_even		(rt_even),
		.write_odd		(write_odd),
		.rt_addr_odd	(rt_addr_odd),
		.rt_odd			(rt_odd),
		.read_addr		(read_addr),
		.read_data		(raw_data)
	);

	// Each port forwards on its own, so a register named in
	// several fields picks up the writeback on all of them
	for (genvar p = 0; p < `SPU_READ_PORTS; p++) begin : g_bypass
		operand_bypass bypass (
			.read_addr		(read_addr[p]),
			.raw_data		(raw_data[p]),
			.write_even		(write_even),
			.write_odd		(write_odd),
			.rt_addr_even	(rt_addr_even),
			.rt_addr_odd	(rt_addr_odd),
			.rt_even		(rt_even),
			.rt_odd			(rt_odd),
			.operand		(fwd_data[p])
		);
	end

	operand_stage stage0 (
		.clk					(clk),
		.reset					(reset),
		.issue_even				(issue_even),
		.issue_odd				(issue_odd),
		.operand_in				(fwd_data),
		.ra_even				(ra_even),
		.rb_even				(rb_even),
		.rc_even				(rc_even),
		.ra_odd					(ra_odd),
		.rb_odd					(rb_odd),
		.rt_st_odd				(rt_st_odd),
		.operands_valid_even	(operands_valid_even),
		.operands_valid_odd		(operands_valid_odd)
	);

endmodule

/* rtl/spu_params.svh */
`ifndef SPU_PARAMS_SVH
`define SPU_PARAMS_SVH

`define SPU_NUM_REGS		128		// Register file depth
`define SPU_READ_PORTS		6		// Three per pipe

// Read port index order:
//   0 even rc, 1 even ra, 2 even rb
//   3 odd rt,  4 odd ra,  5 odd rb

// Source field positions in the instruction word, big-endian
`define SPU_FIELD_RC_LO		25
`define SPU_FIELD_RC_HI		31
`define SPU_FIELD_RA_LO		18
`define SPU_FIELD_RA_HI		24
`define SPU_FIELD_RB_LO		11
`define SPU_FIELD_RB_HI		17

`endif

/* rtl/spu_pkg.sv */
package spu_pkg;

	// All fields use big-endian bit numbering, bit 0 is the MSB

	// One instruction word as it leaves the decoder
	typedef logic [0:31] instr_t;

	// Index into the 128-entry register file
	typedef logic [0:6] reg_addr_t;

	// Full register width, one quadword
	typedef logic [0:127] quad_t;

	// Source fields sit at the same place in every format:
	//   bits 25..31  rc on the even side, rt (store data) on the odd side
	//   bits 18..24  ra
	//   bits 11..17  rb
	// Opcode and immediate bits are not looked at in this stage

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module register_table_tb \
	-f register_table.f \
	-o register_table_sim

./obj_dir/register_table_sim

/* test/register_table_patterns.txt */
# name rst issue_e issue_o instr_e instr_o  we addr_e data_e  wo addr_o data_o
# then expected next cycle: ra_e rb_e rc_e ra_o rb_o rt_o valid_e valid_o (all hex)
#
# Reads straight after reset
reset_read 0 1 1 0000c101 00018284 0 00 0 0 00 0 0 0 0 0 0 0 1 1
reset_idle 0 0 0 0000c101 00018284 0 00 0 0 00 0 0 0 0 0 0 0 0 0
#
# Write then read on all field positions
wr_first   0 0 0 00000000 00000000 1 0a 1111 1 14 2222 0 0 0 0 0 0 0 0
wr_second  0 0 0 00000000 00000000 1 7f 3333 1 00 4444 0 0 0 0 0 0 0 0
rd_both    0 1 1 0005057f 0002bf94 0 00 0 0 00 0 1111 2222 3333 3333 1111 2222 1 1
rd_zero    0 0 1 0005057f ffe00000 0 00 0 0 00 0 1111 2222 3333 4444 4444 4444 0 1
#
# Same-cycle forwarding, repeated fields
fwd_even   0 1 1 000850a1 00050021 1 21 aaaa 0 00 0 aaaa aaaa aaaa 4444 2222 aaaa 1 1
fwd_odd    0 1 1 000299a1 000cd9b3 1 0a 5555 1 33 bbbb bbbb 5555 aaaa bbbb bbbb bbbb 1 1
fwd_hold   0 0 0 000299a1 000cd9b3 0 00 0 0 00 0 bbbb 5555 aaaa bbbb bbbb bbbb 0 0
rd_after   0 1 0 000cc521 000cd9b3 0 00 0 0 00 0 5555 bbbb aaaa bbbb bbbb bbbb 1 0
#
# Both pipes write one register
coll_fwd   0 1 1 00102040 00102040 1 40 e0e0 1 40 0d0d 0d0d 0d0d 0d0d 0d0d 0d0d 0d0d 1 1
coll_read  0 1 1 00002021 001010c0 0 00 0 0 00 0 0d0d 4444 aaaa aaaa 0d0d 0d0d 1 1
coll_split 0 1 0 0010a0c0 001010c0 1 41 1234 1 42 5678 1234 5678 0d0d aaaa 0d0d 0d0d 1 0
#
# Independent pipes and back-to-back issues
even_only  0 1 0 0005057f 001010c0 0 00 0 0 00 0 5555 2222 3333 aaaa 0d0d 0d0d 1 0
odd_only   0 0 1 0005057f 00002141 0 00 0 0 00 0 5555 2222 3333 5678 4444 1234 0 1
b2b_1      0 1 1 00040810 0002bf90 1 10 1001 0 00 0 1001 1001 1001 3333 5555 1001 1 1
b2b_2      0 1 1 00044810 00040811 1 10 1002 1 11 1102 1002 1102 1002 1002 1002 1102 1 1
b2b_3      0 1 1 00040891 0004088a 0 00 0 0 00 0 1102 1002 1102 1102 1002 5555 1 1
#
# Reset in mid-run
pre_reset  0 1 1 0005057f 00002141 0 00 0 0 00 0 5555 2222 3333 5678 4444 1234 1 1
mid_reset  1 0 0 0005057f 00002141 0 00 0 0 00 0 0 0 0 0 0 0 0 0
rst_hold   1 1 1 0005057f 00002141 1 0a dead 0 00 0 0 0 0 0 0 0 0 0
after_rst  0 1 1 0005057f 0002bf94 0 00 0 0 00 0 0 0 0 0 0 0 1 1
post_write 0 1 0 0005057f 0002bf94 1 0a beef 0 00 0 beef 0 0 0 0 0 1 0
final_idle 0 0 0 0005057f 0002bf94 0 00 0 0 00 0 beef 0 0 0 0 0 0 0

/* test/register_table_properties.sv */
`timescale 1ns/1ps

module register_table_properties import spu_pkg::*; (
	input	logic	clk,
	input	logic	reset,
	input	logic	issue_even,
	input	logic	issue_odd,
	input	quad_t	ra_even,
	input	quad_t	rb_even,
	input	quad_t	rc_even,
	input	quad_t	ra_odd,
	input	quad_t	rb_odd,
	input	quad_t	rt_st_odd,
	input	logic	operands_valid_even,
	input	logic	operands_valid_odd
);

	// Valid pulse only follows an issue
	assert property (@(posedge clk) disable iff (reset)
		operands_valid_even |-> $past(issue_even))
		else $error("even valid without a preceding issue");

	assert property (@(posedge clk) disable iff (reset)
		operands_valid_odd |-> $past(issue_odd))
		else $error("odd valid without a preceding issue");

	// Covers the reset cycles and the one right after release
	assert property (@(posedge clk)
		$past(reset) |-> !operands_valid_even && !operands_valid_odd)
		else $error("valid high during or just after reset");

	// Operands move only together with their valid pulse
	assert property (@(posedge clk) disable iff (reset)
		(!operands_valid_even && !$past(reset)) |-> $stable({ra_even, rb_even, rc_even}))
		else $error("even operands changed without valid");

	assert property (@(posedge clk) disable iff (reset)
		(!operands_valid_odd && !$past(reset)) |-> $stable({ra_odd, rb_odd, rt_st_odd}))
		else $error("odd operands changed without valid");

endmodule

bind register_table register_table_properties props0 (
	.clk					(clk),
	.reset					(reset),
	.issue_even				(issue_even),
	.issue_odd				(issue_odd),
	.ra_even				(ra_even),
	.rb_even				(rb_even),
	.rc_even				(rc_even),
	.ra_odd					(ra_odd),
	.rb_odd					(rb_odd),
	.rt_st_odd				(rt_st_odd),
	.operands_valid_even	(operands_valid_even),
	.operands_valid_odd		(operands_valid_odd)
);

/* test/register_table_tb.sv */
`timescale 1ns/1ps

`include "spu_params.svh"

module register_table_tb;
	import spu_pkg::*;

	localparam int MAX_LINES		= 1000;	// Pattern file must end before this
	localparam int RESET_TIMEOUT	= 64;	// Cycles allowed for power-on reset

	logic		clk = 1'b0;
	logic		por_reset = 1'b1;
	logic		pat_reset;					// Reset column of the patterns
	logic		reset;

	instr_t		instr_even;
	instr_t		instr_odd;
	logic		issue_even;
	logic		issue_odd;
	logic		write_even;
	reg_addr_t	rt_addr_even;
	quad_t		rt_even;
	logic		write_odd;
	reg_addr_t	rt_addr_odd;
	quad_t		rt_odd;

	quad_t		ra_even;
	quad_t		rb_even;
	quad_t		rc_even;
	quad_t		ra_odd;
	quad_t		rb_odd;
	quad_t		rt_st_odd;
	logic		operands_valid_even;
	logic		operands_valid_odd;

	// Parsed pattern line
	logic [8*512-1:0]	line;
	logic [8*32-1:0]	name;
	logic				p_rst, p_ie, p_io, p_we, p_wo;
	instr_t				p_instr_e, p_instr_o;
	reg_addr_t			p_addr_e, p_addr_o;
	quad_t				p_data_e, p_data_o;
	quad_t				exp_cur [`SPU_READ_PORTS];	// ra_e rb_e rc_e ra_o rb_o rt_o
	logic				ve_cur, vo_cur;

	// Expectations of the line driven one cycle earlier
	logic [8*32-1:0]	prev_name;
	quad_t				exp_prev [`SPU_READ_PORTS];
	logic				ve_prev, vo_prev;
	logic				have_prev;

	int		fd;
	int		count;
	int		lines;
	int		waited;

	assign reset = por_reset || pat_reset;

	always #2 clk = ~clk;

	register_table dut0 (
		.clk					(clk),
		.reset					(reset),
		.instr_even				(instr_even),
		.instr_odd				(instr_odd),
		.issue_even				(issue_even),
		.issue_odd				(issue_odd),
		.write_even				(write_even),
		.rt_addr_even			(rt_addr_even),
		.rt_even				(rt_even),
		.write_odd				(write_odd),
		.rt_addr_odd			(rt_addr_odd),
		.rt_odd					(rt_odd),
		.ra_even				(ra_even),
		.rb_even				(rb_even),
		.rc_even				(rc_even),
		.ra_odd					(ra_odd),
		.rb_odd					(rb_odd),
		.rt_st_odd				(rt_st_odd),
		.operands_valid_even	(operands_valid_even),
		.operands_valid_odd		(operands_valid_odd)
	);

	task automatic check_quad(input logic [8*32-1:0] test, input string what,
			input quad_t expected, input quad_t actual);
		if (expected !== actual) begin
			$display("FAIL %0s %0s: expected %h actual %h", test, what, expected, actual);
			$display("test failed");
			$fatal(1, "operand mismatch");
		end
	endtask

	task automatic check_valid(input logic [8*32-1:0] test, input string what,
			input logic expected, input logic actual);
		if (expected !== actual) begin
			$display("FAIL %0s %0s: expected %b actual %b", test, what, expected, actual);
			$display("test failed");
			$fatal(1, "valid mismatch");
		end
	endtask

	task automatic check_outputs();
		check_quad(prev_name, "ra_even", exp_prev[0], ra_even);
		check_quad(prev_name, "rb_even", exp_prev[1], rb_even);
		check_quad(prev_name, "rc_even", exp_prev[2], rc_even);
		check_quad(prev_name, "ra_odd", exp_prev[3], ra_odd);
		check_quad(prev_name, "rb_odd", exp_prev[4], rb_odd);
		check_quad(prev_name, "rt_st_odd", exp_prev[5], rt_st_odd);
		check_valid(prev_name, "operands_valid_even", ve_prev, operands_valid_even);
		check_valid(prev_name, "operands_valid_odd", vo_prev, operands_valid_odd);
	endtask

	task automatic drive_idle();
		pat_reset	= 1'b0;
		issue_even	= 1'b0;
		issue_odd	= 1'b0;
		write_even	= 1'b0;
		write_odd	= 1'b0;
	endtask

	task automatic drive_line();
		pat_reset		= p_rst;
		issue_even		= p_ie;
		issue_odd		= p_io;
		instr_even		= p_ie ? p_instr_e : ~p_instr_e;	// Idle slot carries another word
		instr_odd		= p_io ? p_instr_o : ~p_instr_o;
		write_even		= p_we;
		rt_addr_even	= p_addr_e;
		rt_even			= p_data_e;
		write_odd		= p_wo;
		rt_addr_odd		= p_addr_o;
		rt_odd			= p_data_o;
	endtask

	// Power-on reset for 16 cycles
	initial begin
		repeat (16) @(posedge clk);
		#1 por_reset = 1'b0;
	end

	initial begin
		drive_idle();
		instr_even		= '0;
		instr_odd		= '0;
		rt_addr_even	= '0;
		rt_addr_odd		= '0;
		rt_even			= '0;
		rt_odd			= '0;
		have_prev		= 1'b0;
		lines			= 0;

		fd = $fopen("test/register_table_patterns.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file");
			$display("test failed");
			$fatal(1, "no patterns");
		end

		waited = 0;
		while (por_reset) begin
			@(posedge clk);
			waited++;
			if (waited > RESET_TIMEOUT) begin
				$display("Power-on reset was not released in time");
				$display("test failed");
				$fatal(1, "reset timeout");
			end
		end

		while (!$feof(fd)) begin
			lines++;
			if (lines > MAX_LINES) begin
				$display("Pattern file did not end within %0d lines", MAX_LINES);
				$display("test failed");
				$fatal(1, "pattern timeout");
			end
			line = '0;
			name = '0;
			if ($fgets(line, fd) == 0) begin
				continue;
			end
			count = $sscanf(line,
				"%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				name, p_rst, p_ie, p_io, p_instr_e, p_instr_o,
				p_we, p_addr_e, p_data_e, p_wo, p_addr_o, p_data_o,
				exp_cur[0], exp_cur[1], exp_cur[2], exp_cur[3], exp_cur[4], exp_cur[5],
				ve_cur, vo_cur);
			if (count <= 0 || name == 256'("#")) begin
				continue;						// Blank or comment line
			end
			if (count != 20) begin
				$display("Malformed pattern line %0d, %0d fields", lines, count);
				$display("test failed");
				$fatal(1, "bad pattern");
			end

			@(posedge clk);
			#1 drive_line();
			if (have_prev) begin
				#2 check_outputs();
			end
			prev_name	= name;
			exp_prev	= exp_cur;
			ve_prev		= ve_cur;
			vo_prev		= vo_cur;
			have_prev	= 1'b1;
		end
		$fclose(fd);

		// Drain the last line
		@(posedge clk);
		#1 drive_idle();
		if (have_prev) begin
			#2 check_outputs();
		end

		$display("test passed");
		$finish;
	end

endmodule
